//--- common/snd_audio_pkg.sv
/*
  Audio path types: DAC code, sample and filter arithmetic,
  plus the filter shift table indexed by the capacitor enables
*/
`default_nettype none

package snd_audio_pkg;

    typedef logic        [ 7:0] dac_code_t;
    typedef logic signed [15:0] sample_t;
    typedef logic signed [16:0] filt_t;     // One extra bit for x - y

    localparam dac_code_t DAC_MID = 8'h80;  // Zero output

    // Shift with no capacitor switched in
    localparam int unsigned FILT_BASE_SHIFT = 1;

    // Each capacitor adds one to the shift, slower response
    localparam int unsigned FILT_SHIFT [8] = '{
        FILT_BASE_SHIFT,     FILT_BASE_SHIFT + 1, FILT_BASE_SHIFT + 1, FILT_BASE_SHIFT + 2,
        FILT_BASE_SHIFT + 1, FILT_BASE_SHIFT + 2, FILT_BASE_SHIFT + 2, FILT_BASE_SHIFT + 3
    };

endpackage

`default_nettype wire

//--- common/snd_cpu_if.sv
/*
  Sound CPU write bus shared by the decoder and the peripherals
*/
`timescale 1ns/100ps
`default_nettype none

interface snd_cpu_if;
    import snd_map_pkg::*;

    snd_addr_t addr;
    snd_byte_t wdata;
    logic      mreq_n;     // Memory request, active low
    logic      wr_n;       // Write strobe, active low

    // Decoder sees the whole bus
    modport map(
        input addr,
        input wdata,
        input mreq_n,
        input wr_n
    );

    // Peripherals get their select from the decoder instead of mreq_n
    modport periph(
        input addr,
        input wdata,
        input wr_n
    );

endinterface

`default_nettype wire

//--- common/snd_map_pkg.sv
/*
  Sound CPU memory map: page and IO codes, bus types,
  cycle counter width and control register fields
*/
`default_nettype none

package snd_map_pkg;

    // Sound CPU bus
    typedef logic [15:0] snd_addr_t;
    typedef logic [ 7:0] snd_byte_t;

    // 8 kB pages, value of A15..A13
    localparam logic [2:0] PAGE_ROM0  = 3'd0;   // 0000
    localparam logic [2:0] PAGE_ROM1  = 3'd1;   // 2000
    localparam logic [2:0] PAGE_RAM   = 3'd2;   // 4000
    localparam logic [2:0] PAGE_LATCH = 3'd3;   // 6000
    localparam logic [2:0] PAGE_CNT   = 3'd4;   // 8000
    localparam logic [2:0] PAGE_VOICE = 3'd5;   // A000, speech data
    localparam logic [2:0] PAGE_CTRL  = 3'd6;   // C000
    localparam logic [2:0] PAGE_IO    = 3'd7;   // E000

    // IO page, value of A2..A0
    localparam logic [2:0] IO_RDAC    = 3'd0;   // Resistor DAC
    localparam logic [2:0] IO_PSGDATA = 3'd1;   // PSG data latch
    localparam logic [2:0] IO_PSG     = 3'd2;   // PSG write strobe

    // Program ROM window spans two pages
    localparam int ROM_AW = 14;

    // Free running cycle counter
    localparam int CNTW = 11;
    typedef logic [CNTW-1:0] cnt_t;

    // Capacitor enables, top field of the control write
    typedef logic [2:0] cap_t;

    // Speech control bits {rst, st, sel}, only rst set after reset
    localparam logic [2:0] SPCH_CTRL_RST = 3'b100;
    localparam logic       SPCH_BUSY     = 1'b1;   // No speech chip, always busy

    localparam snd_byte_t FLOAT_BYTE = 8'hff;      // Open bus

endpackage

`default_nettype wire

//--- hw/snd_board.sv
/*
  Sound board top level, bus side only
*/
`timescale 1ns/100ps
`default_nettype none

module snd_board #(
    parameter int RAM_AW = 10
)(
    input  wire                             rst,
    input  wire                             clk,
    input  wire                             snd_cen,
    // Sound CPU bus
    input  wire  snd_map_pkg::snd_addr_t    cpu_addr,
    input  wire  snd_map_pkg::snd_byte_t    cpu_wdata,
    input  wire                             cpu_mreq_n,
    input  wire                             cpu_wr_n,
    output snd_map_pkg::snd_byte_t          din,
    // Program ROM
    output logic [snd_map_pkg::ROM_AW-1:0]  rom_addr,
    output logic                            rom_cs,
    input  wire  snd_map_pkg::snd_byte_t    rom_data,
    // From main CPU
    input  wire  snd_map_pkg::snd_byte_t    main_dout,
    input  wire                             m2s_data,
    input  wire                             m2s_irq,
    output logic                            snd_irq,
    // Audio
    output snd_audio_pkg::sample_t          snd,
    output logic                            sample,
    output logic                            peak
);
    import snd_map_pkg::*;

    snd_cpu_if cpu();

    snd_byte_t ram_dout, latch;
    cap_t      cap_en;
    logic      ram_cs, latch_cs, rdac_cs;

    assign cpu.addr   = cpu_addr;
    assign cpu.wdata  = cpu_wdata;
    assign cpu.mreq_n = cpu_mreq_n;
    assign cpu.wr_n   = cpu_wr_n;

    snd_map u_map(
        .rst      (rst),
        .clk      (clk),
        .snd_cen  (snd_cen),
        .cpu      (cpu.map),
        .rom_data (rom_data),
        .ram_dout (ram_dout),
        .latch    (latch),
        .rom_cs   (rom_cs),
        .ram_cs   (ram_cs),
        .latch_cs (latch_cs),
        .rdac_cs  (rdac_cs),
        .cap_en   (cap_en),
        .rom_addr (rom_addr),
        .din      (din)
    );

    snd_latch u_latch(
        .rst       (rst),
        .clk       (clk),
        .main_dout (main_dout),
        .m2s_data  (m2s_data),
        .m2s_irq   (m2s_irq),
        .latch_cs  (latch_cs),
        .cpu       (cpu.periph),
        .latch     (latch),
        .snd_irq   (snd_irq)
    );

    snd_ram #(.RAM_AW(RAM_AW)) u_ram(
        .clk      (clk),
        .ram_cs   (ram_cs),
        .cpu      (cpu.periph),
        .ram_dout (ram_dout)
    );

    snd_dac u_dac(
        .rst     (rst),
        .clk     (clk),
        .snd_cen (snd_cen),
        .rdac_cs (rdac_cs),
        .cap_en  (cap_en),
        .cpu     (cpu.periph),
        .snd     (snd),
        .sample  (sample),
        .peak    (peak)
    );

endmodule

`default_nettype wire

//--- hw/snd_dac.sv
/*
  Resistor DAC register at E000, switched capacitor low pass,
  sample strobe and full scale flag
*/
`timescale 1ns/100ps
`default_nettype none

module snd_dac(
    input  wire                     rst,
    input  wire                     clk,
    input  wire                     snd_cen,
    input  wire                     rdac_cs,
    input  wire  snd_map_pkg::cap_t cap_en,
    snd_cpu_if.periph               cpu,
    output snd_audio_pkg::sample_t  snd,
    output logic                    sample,
    output logic                    peak
);
    import snd_audio_pkg::*;

    dac_code_t code;
    sample_t   x;           // Code recentred, scaled to full 16 bits
    filt_t     diff, step, acc_nxt;
    logic      upd;         // Filter moved on the last edge

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            code <= DAC_MID;
        else if (rdac_cs && !cpu.wr_n)
            code <= cpu.wdata;
    end

    // Flip of the top bit turns offset binary into two's complement
    assign x = {code ^ DAC_MID, 8'h00};

    always_comb begin
        diff    = x - snd;                  // 17 bits, no overflow
        step    = diff >>> FILT_SHIFT[cap_en];
        acc_nxt = snd + step;               // Stays between snd and x
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd    <= '0;
            upd    <= 1'b0;
            sample <= 1'b0;
        end else begin
            if (snd_cen)
                snd <= sample_t'(acc_nxt);
            upd    <= snd_cen;
            sample <= upd;      // One edge after the update
        end
    end

    assign peak = (code == 8'h00) || (code == 8'hff);   // Rails

    // Needs snd_cen to be a true enable, never two in a row
    a_sample_pulse: assert property (@(posedge clk) disable iff (rst)
        sample |=> !sample);

endmodule

`default_nettype wire

//--- hw/snd_latch.sv
/*
  Byte latch from the main CPU and sound interrupt flag
*/
`timescale 1ns/100ps
`default_nettype none

module snd_latch(
    input  wire                           rst,
    input  wire                           clk,
    input  wire  snd_map_pkg::snd_byte_t  main_dout,
    input  wire                           m2s_data,
    input  wire                           m2s_irq,
    input  wire                           latch_cs,
    snd_cpu_if.periph                     cpu,
    output snd_map_pkg::snd_byte_t        latch,
    output logic                          snd_irq
);

    logic irq_ack;

    // Any sound CPU read of the latch page acknowledges
    assign irq_ack = latch_cs && cpu.wr_n;

    always_ff @(posedge clk) begin
        if (m2s_data)
            latch <= main_dout;     // Main CPU write strobe
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd_irq <= 1'b0;
        end else begin
            if (m2s_irq)
                snd_irq <= 1'b1;    // Set wins over ack
            else if (irq_ack)
                snd_irq <= 1'b0;
        end
    end

    a_irq_source: assert property (@(posedge clk) disable iff (rst)
        $rose(snd_irq) |-> $past(m2s_irq));

endmodule

`default_nettype wire

//--- hw/snd_map.sv
/*
  Page decoder, control register at C000, cycle counter
  and read data multiplexer towards the sound CPU
*/
`timescale 1ns/100ps
`default_nettype none

module snd_map(
    input  wire                             rst,
    input  wire                             clk,
    input  wire                             snd_cen,
    snd_cpu_if.map                          cpu,
    input  wire  snd_map_pkg::snd_byte_t    rom_data,
    input  wire  snd_map_pkg::snd_byte_t    ram_dout,
    input  wire  snd_map_pkg::snd_byte_t    latch,
    output logic                            rom_cs,
    output logic                            ram_cs,
    output logic                            latch_cs,
    output logic                            rdac_cs,
    output snd_map_pkg::cap_t               cap_en,
    output logic [snd_map_pkg::ROM_AW-1:0]  rom_addr,
    output snd_map_pkg::snd_byte_t          din
);
    import snd_map_pkg::*;

    logic      cnt_cs, voice_cs, ctrl_cs;
    logic      psgdata_cs, psg_cs;      // Decoded, PSG not fitted
    logic [2:0] spch_ctrl;              // Kept as on the board
    cnt_t      cnt;
    logic      rd_ram;                  // RAM data arrives registered
    snd_byte_t rd_alt;

    assign rom_addr = cpu.addr[ROM_AW-1:0];

    always_comb begin
        rom_cs     = 1'b0;
        ram_cs     = 1'b0;
        latch_cs   = 1'b0;
        cnt_cs     = 1'b0;
        voice_cs   = 1'b0;
        ctrl_cs    = 1'b0;
        rdac_cs    = 1'b0;
        psgdata_cs = 1'b0;
        psg_cs     = 1'b0;
        if (!cpu.mreq_n) begin
            case (cpu.addr[15:13])
                PAGE_ROM0,
                PAGE_ROM1:  rom_cs   = 1'b1;
                PAGE_RAM:   ram_cs   = 1'b1;
                PAGE_LATCH: latch_cs = 1'b1;
                PAGE_CNT:   cnt_cs   = 1'b1;
                PAGE_VOICE: voice_cs = 1'b1;
                PAGE_CTRL:  ctrl_cs  = 1'b1;
                PAGE_IO: begin
                    case (cpu.addr[2:0])    // Sparse decode within the page
                        IO_RDAC:    rdac_cs    = 1'b1;
                        IO_PSGDATA: psgdata_cs = 1'b1;
                        IO_PSG:     psg_cs     = 1'b1;
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    end

    // Control write, data taken from A8..A3
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cap_en    <= '0;
            spch_ctrl <= SPCH_CTRL_RST;
        end else if (ctrl_cs && !cpu.wr_n) begin
            {cap_en, spch_ctrl} <= cpu.addr[8:3];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt    <= '0;
            rd_ram <= 1'b0;
        end else begin
            if (snd_cen)
                cnt <= cnt + 1'b1;  // Wraps freely
            rd_ram <= ram_cs;
        end
    end

    // Everything except RAM is sampled here, ROM first
    always_ff @(posedge clk) begin
        rd_alt <= rom_cs   ? rom_data :
                  cnt_cs   ? {5'h1f, SPCH_BUSY, cnt[CNTW-1 -: 2]} :
                  latch_cs ? latch :
                  FLOAT_BYTE;
    end

    // RAM output is already a register, selected after the fact
    assign din = rd_ram ? ram_dout : rd_alt;

    a_one_select: assert property (@(posedge clk) disable iff (rst)
        $onehot0({rom_cs, ram_cs, latch_cs, cnt_cs, voice_cs,
                  ctrl_cs, rdac_cs, psgdata_cs, psg_cs}));

endmodule

`default_nettype wire

//--- hw/snd_ram.sv
/*
  Sound work RAM, single port, registered read
*/
`timescale 1ns/100ps
`default_nettype none

module snd_ram #(
    parameter int RAM_AW = 10       // 11 on some board revisions
)(
    input  wire                      clk,
    input  wire                      ram_cs,
    snd_cpu_if.periph                cpu,
    output snd_map_pkg::snd_byte_t   ram_dout
);
    import snd_map_pkg::*;

    snd_byte_t         mem [2**RAM_AW];
    logic [RAM_AW-1:0] ram_addr;

    assign ram_addr = cpu.addr[RAM_AW-1:0];    // Upper lines alias

    always_ff @(posedge clk) begin
        if (ram_cs && !cpu.wr_n)
            mem[ram_addr] <= cpu.wdata;
        ram_dout <= mem[ram_addr];      // Read every cycle, old data on write
    end

endmodule

`default_nettype wire

//--- test/snd_board_tb.sv
/*
  Sound board testbench with bus tasks, compare tasks and directed
  tests for decode, RAM, latch, counter and DAC filter
*/
`timescale 1ns/100ps
`default_nettype none

module snd_board_tb;
    import snd_map_pkg::*;
    import snd_audio_pkg::*;

    localparam int CLK_NS = 20;
    localparam int CNT_GAP = 4 * 1024;          // Cycles holding 1024 snd_cen
    localparam int RUN_CYCLES = CNT_GAP + 400;  // Counter gap plus the short tests

    logic             clk = 1'b0;
    logic             rst, snd_cen;
    snd_addr_t        cpu_addr;
    snd_byte_t        cpu_wdata, rom_data, main_dout, din;
    logic             cpu_mreq_n, cpu_wr_n, m2s_data, m2s_irq;
    logic [ROM_AW-1:0] rom_addr;
    logic             rom_cs, snd_irq, sample, peak;
    sample_t          snd;
    logic [1:0]       cen_div = 2'd0;
    logic [1:0]       cen_hist = 2'd0;  // snd_cen seen by the last two edges, older in bit 1
    integer           seed = 32'h302;
    int               errors = 0;
    sample_t          model_y;      // Filter model tracked from the bus
    dac_code_t        model_code;
    cap_t             model_cap;

    snd_board #(.RAM_AW(10)) dut_i(
        .rst(rst), .clk(clk), .snd_cen(snd_cen),
        .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
        .cpu_mreq_n(cpu_mreq_n), .cpu_wr_n(cpu_wr_n), .din(din),
        .rom_addr(rom_addr), .rom_cs(rom_cs), .rom_data(rom_data),
        .main_dout(main_dout), .m2s_data(m2s_data), .m2s_irq(m2s_irq),
        .snd_irq(snd_irq), .snd(snd), .sample(sample), .peak(peak)
    );

    initial forever #(CLK_NS / 2) clk = ~clk;

    always @(posedge clk) begin         // Audio clock enable on one cycle in four
        cen_div  <= cen_div + 2'd1;
        snd_cen  <= (cen_div == 2'd3);
        cen_hist <= {cen_hist[0], snd_cen};
    end

    // y += (x - y) >>> (base + caps) with x the recentred code in the top byte
    function automatic sample_t filter_step(input sample_t y, input dac_code_t code,
                                            input cap_t cap);
        int x, d, sh;
        x  = (int'(code) - int'(DAC_MID)) * 256;
        d  = x - int'(y);
        sh = FILT_BASE_SHIFT + $countones(cap);
        return sample_t'(int'(y) + (d >>> sh));
    endfunction

    // Sees inputs before this edge's updates like the DUT
    always @(posedge clk) begin
        if (rst) begin
            model_y = '0;
            model_code = DAC_MID;
            model_cap = '0;
        end else begin
            if (snd_cen)
                model_y = filter_step(model_y, model_code, model_cap); // Old code applies
            if (!cpu_mreq_n && !cpu_wr_n && cpu_addr[15:13] == PAGE_CTRL)
                model_cap = cpu_addr[8:6];
            if (!cpu_mreq_n && !cpu_wr_n && cpu_addr[15:13] == PAGE_IO
                    && cpu_addr[2:0] == IO_RDAC)
                model_code = cpu_wdata;
        end
    end

    task automatic check_byte(input snd_byte_t got, input snd_byte_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_sample(input sample_t got, input sample_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_rom_addr(input logic [ROM_AW-1:0] got, input logic [ROM_AW-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: rom_addr is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic cpu_write(input snd_addr_t a, input snd_byte_t d);
        @(posedge clk);
        cpu_addr <= a;
        cpu_wdata <= d;
        cpu_mreq_n <= 1'b0;
        cpu_wr_n <= 1'b0;
        @(posedge clk);                 // Write lands on this edge
        cpu_mreq_n <= 1'b1;
        cpu_wr_n <= 1'b1;
    endtask

    task automatic cpu_read(input snd_addr_t a, output snd_byte_t d);
        @(posedge clk);
        cpu_addr <= a;
        cpu_mreq_n <= 1'b0;
        cpu_wr_n <= 1'b1;
        @(posedge clk);                 // Data registered here
        cpu_mreq_n <= 1'b1;
        @(negedge clk);
        d = din;
    endtask

    // Strobe must follow each filter update by one edge
    task automatic wait_sample;
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            check_bit(sample, cen_hist[1], "sample strobe");
        end while (!sample && n < 16);
        if (!sample) begin
            errors++;
            $display("No sample pulse within 16 cycles at %0t ns", $time);
        end
    endtask

    task automatic test_decode;
        snd_addr_t a;
        snd_byte_t d, got;
        for (int i = 0; i < 4; i++) begin
            a = {2'b00, 14'($random(seed))};
            a[13] = i[0];               // Both ROM pages
            d = 8'($random(seed));
            @(posedge clk);
            cpu_addr <= a;
            cpu_mreq_n <= 1'b0;
            cpu_wr_n <= 1'b1;
            rom_data <= d;
            @(negedge clk);
            check_bit(rom_cs, 1'b1, "rom_cs");
            check_rom_addr(rom_addr, a[13:0]);
            @(posedge clk);
            cpu_mreq_n <= 1'b1;
            @(negedge clk);
            check_byte(din, d, "ROM read");
            check_bit(rom_cs, 1'b0, "rom_cs idle");
        end
        cpu_read(16'ha000, got);
        check_byte(got, 8'hff, "speech page read");
        cpu_read(16'he003, got);
        check_byte(got, 8'hff, "unused IO read");
    endtask

    task automatic test_ram;
        logic [9:0] offs [16];
        snd_byte_t  model [1024];
        snd_byte_t  d, got;
        for (int i = 0; i < 16; i++) begin
            offs[i] = 10'($random(seed));
            d = 8'($random(seed));
            cpu_write({6'b010000, offs[i]}, d);
            model[offs[i]] = d;         // Repeats keep the last write
        end
        for (int i = 0; i < 16; i++) begin
            cpu_read({6'b010000, offs[i]}, got);
            check_byte(got, model[offs[i]], "RAM read");
        end
        d = 8'($random(seed));
        cpu_write(16'h4400, d);         // A10 not decoded
        cpu_read(16'h4000, got);
        check_byte(got, d, "RAM alias read");
    endtask

    task automatic test_latch;
        snd_byte_t d, got;
        d = 8'($random(seed));
        @(posedge clk);
        main_dout <= d;
        m2s_data <= 1'b1;
        m2s_irq <= 1'b1;
        @(posedge clk);
        m2s_data <= 1'b0;
        m2s_irq <= 1'b0;
        @(negedge clk);
        check_bit(snd_irq, 1'b1, "snd_irq after pulse");
        cpu_read(16'h6000, got);
        check_byte(got, d, "latch read");
        check_bit(snd_irq, 1'b0, "snd_irq after latch read");
    endtask

    task automatic test_counter;
        snd_byte_t c1, c2;
        logic [1:0] adv;
        cpu_read(16'h8000, c1);
        check_byte({c1[7:2], 2'b00}, 8'hfc, "counter fixed bits");
        repeat (CNT_GAP - 2) @(posedge clk);    // Capture edges CNT_GAP apart
        cpu_read(16'h8000, c2);
        check_byte({c2[7:2], 2'b00}, 8'hfc, "counter fixed bits");
        adv = c2[1:0] - c1[1:0];
        check_byte({6'd0, adv}, 8'd2, "counter top bits advance");
    endtask

    task automatic test_dac;
        dac_code_t codes [3] = '{8'h00, 8'hff, 8'h80};
        logic      peaks [3] = '{1'b1, 1'b1, 1'b0};
        cpu_write({3'b110, 4'd0, 3'b101, 3'b100, 3'b000}, 8'h00);  // Two caps with speech rst kept
        cpu_write(16'he000, 8'($random(seed)));
        for (int i = 0; i < 12; i++) begin
            wait_sample;
            check_sample(snd, model_y, "filter output");
        end
        for (int i = 0; i < 3; i++) begin
            cpu_write(16'he000, codes[i]);
            @(negedge clk);
            check_bit(peak, peaks[i], "peak");
            wait_sample;
            check_sample(snd, model_y, "filter output");
        end
    endtask

    initial begin
        rst = 1'b1;
        snd_cen = 1'b0;
        cpu_addr = '0;
        cpu_wdata = '0;
        cpu_mreq_n = 1'b1;
        cpu_wr_n = 1'b1;
        rom_data = '0;
        main_dout = '0;
        m2s_data = 1'b0;
        m2s_irq = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bit(rom_cs, 1'b0, "rom_cs after reset");
        check_bit(snd_irq, 1'b0, "snd_irq after reset");
        check_bit(sample, 1'b0, "sample after reset");
        check_sample(snd, '0, "snd after reset");
        test_decode;
        test_ram;
        test_latch;
        test_counter;
        test_dac;
        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    initial begin
        #(2 * RUN_CYCLES * CLK_NS);
        $display("Watchdog expired at %0t ns, tests did not complete", $time);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
common/snd_map_pkg.sv
common/snd_audio_pkg.sv
common/snd_cpu_if.sv
hw/snd_map.sv
hw/snd_latch.sv
hw/snd_ram.sv
hw/snd_dac.sv
hw/snd_board.sv
test/snd_board_tb.sv
